/* tb.f */
rover_pkg.sv
ir_command_receiver.sv
command_fifo.sv
motor_signal_stream.sv
rover_drive_top.sv
rover_drive_assertions.sv
tb_rover_drive.sv

/* tb_rover_drive.sv */
module tb_rover_drive;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int step_cycles = 16;
   // worst case frame length in cycles with the widths drawn below
   localparam int frame_max_cycles = 500;

   typedef struct packed {
      logic        l;
      logic        r;
      logic [15:0] len;
   } episode_t;

   logic clk100_mhz = 1'b0;
   logic reset;
   logic ir_in;
   logic motor_l;
   logic motor_r;
   logic moving;
   logic frame_error;
   logic overflow;

   logic [15:0] lfsr_state = 16'd65;
   episode_t expected_q[$];
   episode_t seen_q[$];
   event episode_seen;
   int episodes_expected = 0;
   int episodes_checked = 0;
   int error_count = 0;
   int tests_passed = 0;
   int tests_failed = 0;
   int overflow_count = 0;
   int frame_error_count = 0;
   int budget_cycles = 0;
   int cycle_count = 0;
   logic        run_l;
   logic        run_r;
   logic [15:0] run_len = '0;

   rover_drive_top #(.tick_cycles(4), .step_cycles(step_cycles), .fifo_depth(4)) UUT (.*);

   initial begin
      forever #5 clk100_mhz = ~clk100_mhz;
   end

   // stop a stuck run
   // the limit grows with every frame and episode queued
   always @(posedge clk100_mhz) begin
      cycle_count = cycle_count + 1;
      if (cycle_count > 2 * budget_cycles + 2000) begin
         $display("timeout: run passed %0d cycles without finishing", cycle_count);
         $display("SOME TESTS FAILED");
         $finish;
      end
   end

   //////////////////////////////////////////////////
   // stimulus helpers

   // 16-bit fibonacci lfsr with taps 16 14 13 11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   task automatic draw_bits(input int n, output logic [15:0] val);
      val = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         val = {val[14:0], lfsr_state[0]};
      end
   endtask

   task automatic hold_ir(input logic level, input int cycles);
      ir_in = level;
      repeat (cycles) @(negedge clk100_mhz);
   endtask

   // start lasts 10 ticks and gaps about 2 ticks
   // zeros last 1 tick and ones 4 to 5 ticks
   task automatic send_frame(input logic [11:0] word, input int nbits);
      logic [15:0] r;
      budget_cycles = budget_cycles + frame_max_cycles;
      hold_ir(1'b1, 40);
      for (int i = 11; i > 11 - nbits; i--) begin
         draw_bits(2, r);
         hold_ir(1'b0, 8 + r);
         if (word[i]) begin
            draw_bits(3, r);
            hold_ir(1'b1, 16 + r);
         end else begin
            draw_bits(2, r);
            hold_ir(1'b1, 4 + r);
         end
      end
      hold_ir(1'b0, 12);
   endtask

   // reference model maps one command word to its motor episode
   // len 0 means no episode
   function automatic episode_t expected_episode(input logic [11:0] word);
      episode_t ep;
      ep = '0;
      case (word[11:8])
         4'd0: begin
            ep.l   = 1'b1;
            ep.r   = 1'b1;
            ep.len = 16'(word[7:0] * step_cycles);
         end
         4'd1: begin
            ep.l   = word[7];
            ep.r   = !word[7];
            ep.len = 16'(word[6:0] * step_cycles);
         end
         default: ep = '0;
      endcase
      if (ep.len == 0) ep = '0;
      return ep;
   endfunction

   task automatic queue_command(input logic [11:0] word);
      episode_t ep;
      ep = expected_episode(word);
      if (ep.len != 0) begin
         expected_q.push_back(ep);
         episodes_expected = episodes_expected + 1;
         budget_cycles = budget_cycles + ep.len + 4;
      end
      send_frame(word, 12);
   endtask

   task automatic wait_until_idle();
      wait (episodes_checked == episodes_expected && !moving);
      @(negedge clk100_mhz);
   endtask

   task automatic report_test(input string name, input int err_start);
      if (error_count == err_start) begin
         tests_passed = tests_passed + 1;
         $display("test %s: passed", name);
      end else begin
         tests_failed = tests_failed + 1;
         $display("test %s: failed with %0d errors", name, error_count - err_start);
      end
   endtask

   //////////////////////////////////////////////////
   // monitor and compare

   // outputs are sampled mid cycle where they are settled
   always @(negedge clk100_mhz) begin
      if (!reset) begin
         if (moving) begin
            if (run_len == 0) begin
               run_l = motor_l;
               run_r = motor_r;
            end
            run_len = run_len + 1'b1;
         end else if (run_len != 0) begin
            seen_q.push_back({run_l, run_r, run_len});
            run_len = '0;
            -> episode_seen;
         end
         if (overflow) overflow_count = overflow_count + 1;
         if (frame_error) frame_error_count = frame_error_count + 1;
      end
   end

   initial begin
      episode_t got;
      episode_t exp;
      forever begin
         @(episode_seen);
         while (seen_q.size() > 0) begin
            got = seen_q.pop_front();
            if (expected_q.size() == 0) begin
               $display("[ERROR] %0t: episode l=%b r=%b len=%0d played with no command queued",
                        $time, got.l, got.r, got.len);
               error_count = error_count + 1;
            end else begin
               exp = expected_q.pop_front();
               if (got != exp) begin
                  $display("[ERROR] %0t: expected l=%b r=%b len=%0d, got l=%b r=%b len=%0d",
                           $time, exp.l, exp.r, exp.len, got.l, got.r, got.len);
                  error_count = error_count + 1;
               end
               episodes_checked = episodes_checked + 1;
            end
         end
      end
   end

   //////////////////////////////////////////////////
   // test sequence

   initial begin
      logic [15:0] r;
      logic [15:0] amt;
      int err_start;
      int ovf_start;
      int ferr_start;
      reset = 1'b1;
      ir_in = 1'b0;
      repeat (10) @(negedge clk100_mhz);
      reset = 1'b0;
      @(negedge clk100_mhz);

      // single drive on both motors
      err_start = error_count;
      draw_bits(8, amt);
      queue_command({4'd0, amt[7:0] | 8'd1});
      wait_until_idle();
      report_test("drive", err_start);

      // turn left then turn right
      err_start = error_count;
      draw_bits(7, amt);
      queue_command({4'd1, 1'b0, amt[6:0] | 7'd1});
      draw_bits(7, amt);
      queue_command({4'd1, 1'b1, amt[6:0] | 7'd1});
      wait_until_idle();
      report_test("turns", err_start);

      // short episodes never outlast a frame so the fifo stays shallow
      err_start = error_count;
      ovf_start = overflow_count;
      for (int i = 0; i < 10; i++) begin
         draw_bits(2, r);
         draw_bits(3, amt);
         case (r[1:0])
            2'd0: queue_command({4'd0, 5'd0, amt[2:0]});
            2'd1: queue_command({4'd1, amt[0], 4'd0, amt[2:0]});
            2'd2: queue_command({4'(2 + amt[2:0]), 8'd5});
            default: queue_command({4'd1, amt[0], 7'd0});
         endcase
      end
      wait_until_idle();
      if (overflow_count != ovf_start) begin
         $display("[ERROR] %0t: burst raised %0d overflow pulses", $time,
                  overflow_count - ovf_start);
         error_count = error_count + 1;
      end
      report_test("burst", err_start);

      // six frames while the longest drive plays
      // the last two find the fifo full
      err_start = error_count;
      ovf_start = overflow_count;
      queue_command({4'd0, 8'd255});
      wait (moving);
      @(negedge clk100_mhz);
      for (int i = 0; i < 6; i++) begin
         draw_bits(4, amt);
         if (i < 4) begin
            queue_command({3'd0, amt[3], 5'd0, amt[2:0] | 3'd1});
         end else begin
            send_frame({3'd0, amt[3], 5'd0, amt[2:0] | 3'd1}, 12);
         end
      end
      if (!moving) begin
         $display("long drive ended before all six frames were sent");
         error_count = error_count + 1;
      end
      wait_until_idle();
      if (overflow_count - ovf_start != 2) begin
         $display("[ERROR] %0t: expected 2 overflow pulses, got %0d", $time,
                  overflow_count - ovf_start);
         error_count = error_count + 1;
      end
      report_test("overflow", err_start);

      // a cut frame aborts and the next frame plays
      err_start = error_count;
      ferr_start = frame_error_count;
      draw_bits(3, r);
      send_frame({4'd0, 8'd3}, 2 + r[2:0]);
      wait (frame_error_count == ferr_start + 1);
      draw_bits(7, amt);
      queue_command({4'd1, 1'b1, amt[6:0] | 7'd1});
      wait_until_idle();
      if (frame_error_count - ferr_start != 1) begin
         $display("[ERROR] %0t: expected 1 frame error pulse, got %0d", $time,
                  frame_error_count - ferr_start);
         error_count = error_count + 1;
      end
      report_test("frame error", err_start);

      // stray pulses in any other test show up in the run totals
      if (frame_error_count != 1 || overflow_count != 2) begin
         $display("[ERROR] %0t: run total of %0d frame errors and %0d overflows, expected 1 and 2",
                  $time, frame_error_count, overflow_count);
         error_count = error_count + 1;
      end
      if (seen_q.size() != 0 || expected_q.size() != 0) begin
         $display("episodes left unmatched at the end of the run");
         error_count = error_count + 1;
      end
      $display("tests passed %0d, failed %0d, episodes checked %0d, errors %0d",
               tests_passed, tests_failed, episodes_checked, error_count);
      if (error_count == 0 && tests_failed == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

/* rover_drive_assertions.sv */
module rover_drive_assertions (
   input logic clk100_mhz,
   input logic reset,
   input logic motor_l,
   input logic motor_r,
   input logic moving,
   input logic frame_error,
   input logic overflow,
   input logic cmd_strobe
);

   timeunit 1ns;
   timeprecision 100ps;

   // a motor line is only ever on inside an episode
   motor_within_moving: assert property (@(posedge clk100_mhz) disable iff (reset)
      (motor_l || motor_r) |-> moving)
      else $error("motor line high while not moving");

   // end of an episode takes both lines down in the same cycle
   lines_drop_together: assert property (@(posedge clk100_mhz) disable iff (reset)
      ($fell(moving) || $fell(motor_l) || $fell(motor_r)) |-> (!moving && !motor_l && !motor_r))
      else $error("moving and motor lines did not drop together");

   // drops only happen on a write attempt
   overflow_on_strobe: assert property (@(posedge clk100_mhz) disable iff (reset)
      overflow |-> cmd_strobe)
      else $error("overflow without a command strobe");

   // a frame either completes or aborts, never both
   error_or_strobe: assert property (@(posedge clk100_mhz) disable iff (reset)
      !(frame_error && cmd_strobe))
      else $error("frame error and command strobe in the same cycle");

endmodule

bind rover_drive_top rover_drive_assertions rules (.*);

/* rover_drive_top.sv */
module rover_drive_top
   import rover_pkg::*;
#(
   parameter int tick_cycles = 10000,
   parameter int step_cycles = 100000,
   parameter int fifo_depth  = 4
) (
   input  logic clk100_mhz,
   input  logic reset,
   input  logic ir_in,
   output logic motor_l,
   output logic motor_r,
   output logic moving,
   output logic frame_error,
   output logic overflow
);

   // receiver to fifo
   logic      cmd_strobe;
   move_cmd_t cmd;

   // fifo to motor stream
   move_cmd_t head;
   logic      available;
   logic      take;

   ir_command_receiver #(
      .tick_cycles(tick_cycles)
   ) receiver (
      .clk100_mhz (clk100_mhz),
      .reset      (reset),
      .ir_in      (ir_in),
      .cmd_strobe (cmd_strobe),
      .cmd        (cmd),
      .frame_error(frame_error)
   );

   // no back pressure, a full fifo drops and flags
   command_fifo #(
      .fifo_depth(fifo_depth)
   ) cmd_fifo (
      .clk100_mhz(clk100_mhz),
      .reset     (reset),
      .cmd_strobe(cmd_strobe),
      .cmd       (cmd),
      .take      (take),
      .head      (head),
      .available (available),
      .overflow  (overflow)
   );

   motor_signal_stream #(
      .step_cycles(step_cycles)
   ) motor_stream (
      .clk100_mhz(clk100_mhz),
      .reset     (reset),
      .head      (head),
      .available (available),
      .take      (take),
      .motor_l   (motor_l),
      .motor_r   (motor_r),
      .moving    (moving)
   );

endmodule

/* motor_signal_stream.sv */
module motor_signal_stream
   import rover_pkg::*;
#(
   parameter int step_cycles = 100000
) (
   input  logic      clk100_mhz,
   input  logic      reset,
   input  move_cmd_t head,
   input  logic      available,
   output logic      take,
   output logic      motor_l,
   output logic      motor_r,
   output logic      moving
);

   localparam int presc_bits = $clog2(step_cycles + 1);

   // stream states
   localparam logic [1:0] s_idle = 2'd0;
   localparam logic [1:0] s_run  = 2'd1;
   localparam logic [1:0] s_rest = 2'd2;

   logic [1:0]            state;
   logic                  dec_l;
   logic                  dec_r;
   logic [7:0]            dec_amount;
   logic                  sel_l;
   logic                  sel_r;
   logic [7:0]            steps_left;
   logic [presc_bits-1:0] step_presc;
   logic                  step_done;

   //////////////////////////////////////////////////
   // command decode

   // op picks which union view the low byte is read through
   always_comb begin
      dec_l      = 1'b0;
      dec_r      = 1'b0;
      dec_amount = '0;
      case (head.drive.op)
         op_drive: begin
            dec_l      = 1'b1;
            dec_r      = 1'b1;
            dec_amount = head.drive.distance;
         end
         op_turn: begin
            dec_l      = head.turn.side;
            dec_r      = ~head.turn.side;
            dec_amount = {1'b0, head.turn.angle};
         end
         // unknown ops leave amount at zero and are dropped
         default: dec_amount = '0;
      endcase
   end

   // pop as soon as a command waits and we are idle
   assign take = (state == s_idle) && available;

   //////////////////////////////////////////////////
   // episode timing

   assign step_done = (step_presc == presc_bits'(step_cycles - 1));

   always_ff @(posedge clk100_mhz) begin
      if (reset) begin
         state      <= s_idle;
         sel_l      <= 1'b0;
         sel_r      <= 1'b0;
         steps_left <= '0;
         step_presc <= '0;
      end else begin
         case (state)
            s_idle: begin
               // zero amounts are consumed and nothing plays
               if (take && (dec_amount != '0)) begin
                  sel_l      <= dec_l;
                  sel_r      <= dec_r;
                  steps_left <= dec_amount;
                  step_presc <= '0;
                  state      <= s_run;
               end
            end
            s_run: begin
               if (step_done) begin
                  step_presc <= '0;
                  if (steps_left == 8'd1) begin
                     state <= s_rest;
                  end else begin
                     steps_left <= steps_left - 1'b1;
                  end
               end else begin
                  step_presc <= step_presc + 1'b1;
               end
            end
            // one quiet cycle between episodes
            s_rest:  state <= s_idle;
            default: state <= s_idle;
         endcase
      end
   end

   // lines drop together when run ends
   assign moving  = (state == s_run);
   assign motor_l = moving & sel_l;
   assign motor_r = moving & sel_r;

endmodule

/* command_fifo.sv */
module command_fifo
   import rover_pkg::*;
#(
   parameter int fifo_depth = 4
) (
   input  logic      clk100_mhz,
   input  logic      reset,
   input  logic      cmd_strobe,
   input  move_cmd_t cmd,
   input  logic      take,
   output move_cmd_t head,
   output logic      available,
   output logic      overflow
);

   localparam int ptr_bits   = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
   localparam int count_bits = $clog2(fifo_depth + 1);

   move_cmd_t             mem [fifo_depth];
   logic [ptr_bits-1:0]   wr_ptr;
   logic [ptr_bits-1:0]   rd_ptr;
   logic [count_bits-1:0] count;
   logic                  full;
   logic                  push;
   logic                  pop;

   // pointer step with wrap for any depth
   function automatic logic [ptr_bits-1:0] next_ptr(input logic [ptr_bits-1:0] ptr);
      if (ptr == ptr_bits'(fifo_depth - 1)) begin
         return '0;
      end
      return ptr + 1'b1;
   endfunction

   assign full      = (count == count_bits'(fifo_depth));
   assign available = (count != '0);
   assign head      = mem[rd_ptr];

   // a pop frees the slot the write needs, even when full
   assign pop      = take && available;
   assign push     = cmd_strobe && (!full || pop);
   assign overflow = cmd_strobe && !push;

   always_ff @(posedge clk100_mhz) begin
      if (push) mem[wr_ptr] <= cmd;
   end

   always_ff @(posedge clk100_mhz) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) wr_ptr <= next_ptr(wr_ptr);
         if (pop) rd_ptr <= next_ptr(rd_ptr);
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

/* ir_command_receiver.sv */
module ir_command_receiver
   import rover_pkg::*;
#(
   parameter int tick_cycles = 10000
) (
   input  logic      clk100_mhz,
   input  logic      reset,
   input  logic      ir_in,
   output logic      cmd_strobe,
   output move_cmd_t cmd,
   output logic      frame_error
);

   localparam int presc_bits = $clog2(tick_cycles + 1);

   // receiver states
   localparam logic [1:0] s_idle  = 2'd0;
   localparam logic [1:0] s_start = 2'd1;
   localparam logic [1:0] s_data  = 2'd2;
   localparam logic [1:0] s_gap   = 2'd3;

   logic [1:0]                 state;
   logic                       ir_q;
   logic                       rise;
   logic                       fall;
   logic                       level_change;
   logic [presc_bits-1:0]      presc;
   logic                       tick;
   logic [tick_count_bits-1:0] width_cnt;
   logic [tick_count_bits-1:0] width_next;
   logic [cmd_bits-1:0]        shift_reg;
   logic [3:0]                 bit_cnt;
   logic                       data_bit;

   //////////////////////////////////////////////////
   // pulse width measurement

   assign rise         = ir_in & ~ir_q;
   assign fall         = ~ir_in & ir_q;
   assign level_change = rise | fall;

   // tick on the last cycle of each prescaler period
   assign tick = (presc == presc_bits'(tick_cycles - 1));

   // width including a tick that completes this cycle, saturating
   always_comb begin
      if (tick && (width_cnt != '1)) begin
         width_next = width_cnt + 1'b1;
      end else begin
         width_next = width_cnt;
      end
   end

   // short pulses are zeros, medium pulses are ones
   assign data_bit = (width_next >= one_ticks);

   // every level change restarts both counters
   // so a partial tick at the end of a pulse is dropped
   always_ff @(posedge clk100_mhz) begin
      if (reset) begin
         ir_q      <= 1'b0;
         presc     <= '0;
         width_cnt <= '0;
      end else begin
         ir_q <= ir_in;
         if (level_change) begin
            presc     <= '0;
            width_cnt <= '0;
         end else begin
            presc     <= tick ? '0 : presc + 1'b1;
            width_cnt <= width_next;
         end
      end
   end

   //////////////////////////////////////////////////
   // frame state machine

   always_ff @(posedge clk100_mhz) begin
      if (reset) begin
         state       <= s_idle;
         bit_cnt     <= '0;
         cmd_strobe  <= 1'b0;
         frame_error <= 1'b0;
      end else begin
         // strobes are single cycle
         cmd_strobe  <= 1'b0;
         frame_error <= 1'b0;
         case (state)
            s_idle: begin
               if (rise) state <= s_start;
            end
            s_start: begin
               // too short for a start, back to waiting
               if (fall) begin
                  if (width_next >= start_ticks) begin
                     bit_cnt <= '0;
                     state   <= s_gap;
                  end else begin
                     state <= s_idle;
                  end
               end
            end
            s_gap: begin
               if (rise) begin
                  state <= s_data;
               end else if (width_next >= gap_timeout_ticks) begin
                  // sender went quiet mid frame
                  frame_error <= 1'b1;
                  state       <= s_idle;
               end
            end
            s_data: begin
               if (fall) begin
                  if (width_next >= start_ticks) begin
                     // a fresh start pulse, begin the frame over
                     bit_cnt <= '0;
                     state   <= s_gap;
                  end else if (bit_cnt == cmd_bits - 1) begin
                     cmd_strobe <= 1'b1;
                     state      <= s_idle;
                  end else begin
                     bit_cnt <= bit_cnt + 1'b1;
                     state   <= s_gap;
                  end
               end
            end
            default: state <= s_idle;
         endcase
      end
   end

   // msb first shift, word handed out with the last bit
   always_ff @(posedge clk100_mhz) begin
      if ((state == s_data) && fall && (width_next < start_ticks)) begin
         shift_reg <= {shift_reg[cmd_bits-2:0], data_bit};
         if (bit_cnt == cmd_bits - 1) begin
            cmd <= {shift_reg[cmd_bits-2:0], data_bit};
         end
      end
   end

endmodule

/* rover_pkg.sv */
package rover_pkg;

   //////////////////////////////////////////////////
   // move command word

   // width of one move command as sent over ir
   localparam int cmd_bits = 12;

   // opcodes carried in the top nibble
   // anything other than drive or turn is a no-op
   typedef enum logic [3:0] {
      op_drive = 4'd0,
      op_turn  = 4'd1
   } cmd_op_t;

   // drive view, both motors on for distance steps
   typedef struct packed {
      cmd_op_t    op;
      logic [7:0] distance;
   } drive_view_t;

   // turn view, one motor on for angle steps
   // side 0 runs the right motor (turn left)
   // side 1 runs the left motor (turn right)
   typedef struct packed {
      cmd_op_t    op;
      logic       side;
      logic [6:0] angle;
   } turn_view_t;

   // one 12-bit word, read through the view its op selects
   typedef union packed {
      drive_view_t drive;
      turn_view_t  turn;
   } move_cmd_t;

   //////////////////////////////////////////////////
   // ir pulse classification, all in ticks

   // high pulse at least this long marks a frame start
   localparam int start_ticks = 8;
   // data pulse of one_ticks up to start_ticks-1 is a one, shorter is a zero
   localparam int one_ticks = 3;
   // low gap this long inside a frame aborts it
   localparam int gap_timeout_ticks = 16;
   // tick counters saturate at 31
   localparam int tick_count_bits = 5;

endpackage
